//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_car_traffic
FILELIST := vlog.f
LOG      := sim.log
FAIL_MSG := Testbench failed
PASS_MSG := Testbench passed

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard tb/*.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- tb/tb_car_model.svh
// Expected car rows, colour generator states and pair phases, included inside the testbench top
`ifndef TB_CAR_MODEL_SVH
`define TB_CAR_MODEL_SVH

coord_y_t model_row     [0:MAX_CARS-1];
lfsr_t    model_lfsr    [0:MAX_CARS-1];
bit       model_draw    [0:MAX_CARS-1];  // Next plot of this car is a draw
int       model_pending [0:MAX_CARS-1];  // Steps whose erase is still outstanding
int       model_count;                   // Expected step counter value
int       car0_pairs;                    // Completed erase and draw pairs of car 0

// One Galois step, right shift with the taps folded in on a one out
function automatic lfsr_t colour_step(lfsr_t s);
    lfsr_t stepped;
    stepped = s >> 1;
    if (s[0])
        stepped = stepped ^ LFSR_TAPS;
    return stepped;
endfunction

// Row below, back to the top after the last row
function automatic coord_y_t row_after(coord_y_t r);
    if (int'(r) == SCREEN_HEIGHT - 1)
        return '0;
    return r + coord_y_t'(1);
endfunction

// Car index owning a column, or -1 when no lane uses it
function automatic int car_at_column(coord_x_t x);
    int found;
    found = -1;
    for (int i = 0; i < NUM_CARS; i++)
    begin
        if (LANE_COLUMN[i] == x)
            found = i;
    end
    return found;
endfunction

function automatic bit all_idle();
    bit idle;
    idle = 1'b1;
    for (int i = 0; i < NUM_CARS; i++)
    begin
        if (model_pending[i] != 0 || model_draw[i])
            idle = 1'b0;
    end
    return idle;
endfunction

task automatic clear_model();
    for (int i = 0; i < MAX_CARS; i++)
    begin
        model_row[i]     = '0;  // Every car starts at the top
        model_lfsr[i]    = LANE_SEED[i];
        model_draw[i]    = 1'b0;
        model_pending[i] = 0;
    end
    model_count = 0;
    car0_pairs  = 0;
endtask

`endif

//--- tb/tb_car_traffic.sv
// Testbench for the lane animator; toggles run in random stretches and checks every plot
`timescale 1ns/1ps
`default_nettype none

module tb_car_traffic
    import car_pkg::*;
();

    localparam int NUM_CARS      = 9;
    localparam int STEP_PERIOD   = 40;
    localparam int CAR0_STEPS    = 300;
    localparam int MAX_STRETCHES = 600;  // Bound on the run toggling loop
    localparam int DRAIN_TIMEOUT = 200;  // Clocks allowed to finish pending pixels
    localparam logic [15:0] RAND_SEED = 16'd75;
    localparam logic [15:0] RAND_TAPS = 16'hB400;

    logic     clk;
    logic     reset_n;
    logic     run;
    logic     plot;
    coord_x_t plot_x;
    coord_y_t plot_y;
    colour_t  plot_colour;

    logic [15:0] rand_state;
    bit          first_low;  // High over the first run-low stretch after reset

    `include "tb_car_model.svh"

    car_traffic_top #(
        .NUM_CARS    (NUM_CARS),
        .STEP_PERIOD (STEP_PERIOD)
    ) UUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .run         (run),
        .plot        (plot),
        .plot_x      (plot_x),
        .plot_y      (plot_y),
        .plot_colour (plot_colour)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first failed check");
    endtask

    // Galois LFSR, one step per bit taken
    function automatic bit rand_bit();
        bit out;
        out        = rand_state[0];
        rand_state = rand_state >> 1;
        if (out)
            rand_state = rand_state ^ RAND_TAPS;
        return out;
    endfunction

    function automatic int rand_bits(int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++)
            value = (value << 1) | int'(rand_bit());
        return value;
    endfunction

    // Compares one plot with the model and moves the model on
    task automatic check_plot();
        int       car;
        coord_y_t expect_y;
        colour_t  expect_colour;
        car = car_at_column(plot_x);
        assert (car >= 0)
        else
        begin
            $display("[ERROR] plot_x got %h, which is no lane column", plot_x);
            report_failure();
        end
        assert (int'(plot_y) < SCREEN_HEIGHT)
        else
        begin
            $display("[ERROR] plot_y got %h, limit %h", plot_y, SCREEN_HEIGHT);
            report_failure();
        end
        if (!model_draw[car])
        begin
            assert (model_pending[car] > 0)
            else
            begin
                $display("Car %0d plotted an erase without a step", car);
                report_failure();
            end
            expect_y      = model_row[car];
            expect_colour = BLACK;
            model_pending[car]--;
            model_draw[car] = 1'b1;
        end
        else
        begin
            expect_y = row_after(model_row[car]);
            if (expect_y == '0)
                model_lfsr[car] = colour_step(model_lfsr[car]);  // Wrap picks a new colour
            expect_colour   = model_lfsr[car][COLOUR_WIDTH-1:0];
            model_row[car]  = expect_y;
            model_draw[car] = 1'b0;
            if (car == 0)
                car0_pairs++;
        end
        assert (plot_y == expect_y)
        else
        begin
            $display("[ERROR] car %0d plot_y got %h expected %h", car, plot_y, expect_y);
            report_failure();
        end
        assert (plot_colour == expect_colour)
        else
        begin
            $display("[ERROR] car %0d plot_colour got %h expected %h",
                     car, plot_colour, expect_colour);
            report_failure();
        end
    endtask

    // Step model on the rising edge, plot checks on the falling edge
    initial
    begin
        clear_model();
        forever
        begin
            @(posedge clk);
            if (!reset_n)
            begin
                model_count = 0;
            end
            else if (run)
            begin
                if (model_count < NUM_CARS)
                begin
                    assert (model_pending[model_count] == 0 && !model_draw[model_count])
                    else
                    begin
                        $display("Car %0d was stepped before its last pair was plotted",
                                 model_count);
                        report_failure();
                    end
                    model_pending[model_count]++;
                end
                if (model_count == STEP_PERIOD - 1)
                    model_count = 0;
                else
                    model_count++;
            end
            @(negedge clk);
            if (reset_n)
            begin
                if (first_low)
                begin
                    assert (!plot)
                    else
                    begin
                        $display("[ERROR] plot got %h expected %h before run", plot, 1'b0);
                        report_failure();
                    end
                end
                if (plot)
                    check_plot();
            end
        end
    end

    initial
    begin
        int stretches;
        int len;
        int waited;
        reset_n    = 1'b0;
        run        = 1'b0;
        first_low  = 1'b0;
        rand_state = RAND_SEED;
        repeat (2) @(negedge clk);
        reset_n   = 1'b1;
        first_low = 1'b1;
        len = 4 + rand_bits(4);
        repeat (len) @(negedge clk);
        first_low = 1'b0;

        stretches = 0;
        while (car0_pairs < CAR0_STEPS && stretches < MAX_STRETCHES)
        begin
            run = 1'b1;
            len = 8 + rand_bits(8);  // Long enough for several step windows
            repeat (len) @(negedge clk);
            run = 1'b0;
            len = 1 + rand_bits(5);
            repeat (len) @(negedge clk);
            stretches++;
        end

        // Let every started pair finish
        waited = 0;
        while (!all_idle() && waited < DRAIN_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end

        if (car0_pairs >= CAR0_STEPS && all_idle())
        begin
            $display("Testbench passed");
            $finish;
        end
        else
        begin
            if (car0_pairs < CAR0_STEPS)
                $display("Timeout: car 0 finished only %0d of %0d steps",
                         car0_pairs, CAR0_STEPS);
            else
                $display("Timeout: cars still had pixels pending after run went low");
            report_failure();
        end
    end

endmodule

`default_nettype wire

//--- verilog/car_lane.sv
// One falling car in a fixed column; on each step it requests an erase, moves down, requests a draw
`timescale 1ns/1ps
`default_nettype none

module car_lane
    import car_pkg::*;
#(
    parameter coord_x_t LANE_X = 8'd0,
    parameter lfsr_t    SEED   = 8'h01
)
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     step,
    input  logic     pixel_grant,
    output logic     pixel_valid,
    output coord_x_t pixel_x,
    output coord_y_t pixel_y,
    output colour_t  pixel_colour
);

    // Erase and draw each hold their request until granted
    // The move itself happens on the erase grant edge
    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_ERASE = 2'd1,
        S_DRAW  = 2'd2
    } state_t;

    state_t   state;
    state_t   next_state;
    coord_y_t row;
    coord_y_t next_row;
    colour_t  car_colour;
    logic     at_bottom;
    logic     erase_done;
    logic     draw_done;
    logic     advance;

    assign erase_done = (state == S_ERASE) && pixel_grant;
    assign draw_done  = (state == S_DRAW) && pixel_grant;

    assign at_bottom = (row == coord_y_t'(SCREEN_HEIGHT - 1));

    // Bottom row wraps to the top
    assign next_row = at_bottom ? coord_y_t'(0) : row + coord_y_t'(1);

    // New colour on wrap, ready before the draw is presented
    assign advance = erase_done && at_bottom;

    colour_lfsr #(
        .SEED (SEED)
    ) u_colour_lfsr (
        .clk     (clk),
        .reset_n (reset_n),
        .advance (advance),
        .colour  (car_colour)
    );

    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:
            begin
                if (step)
                    next_state = S_ERASE;
            end
            S_ERASE:
            begin
                if (erase_done)
                    next_state = S_DRAW;  // Move and draw request on the same edge
            end
            S_DRAW:
            begin
                if (draw_done)
                    next_state = S_IDLE;
            end
            default:
            begin
                next_state = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= S_IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    // Row register, every car starts at the top
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            row <= '0;
        end
        else if (erase_done)
        begin
            row <= next_row;
        end
    end

    // Erase uses the old row, draw the updated one
    assign pixel_valid  = (state == S_ERASE) || (state == S_DRAW);
    assign pixel_x      = LANE_X;  // Lane never changes column
    assign pixel_y      = row;
    assign pixel_colour = (state == S_ERASE) ? BLACK : car_colour;

endmodule

`default_nettype wire

//--- verilog/car_pkg.sv
// Screen geometry, pixel types and per-lane tables shared by every module of the lane animator
`default_nettype none

package car_pkg;

    // Display size in pixels
    localparam int SCREEN_WIDTH  = 160;
    localparam int SCREEN_HEIGHT = 120;

    // Coordinate widths follow from the screen size
    localparam int X_WIDTH = $clog2(SCREEN_WIDTH);   // 8 bits
    localparam int Y_WIDTH = $clog2(SCREEN_HEIGHT);  // 7 bits

    localparam int COLOUR_WIDTH = 3;  // One bit each of red, green, blue
    localparam int LFSR_WIDTH   = 8;

    typedef logic [X_WIDTH-1:0]      coord_x_t;
    typedef logic [Y_WIDTH-1:0]      coord_y_t;
    typedef logic [COLOUR_WIDTH-1:0] colour_t;
    typedef logic [LFSR_WIDTH-1:0]   lfsr_t;

    localparam int MAX_CARS = 9;

    // Column of each lane, evenly spaced across the left part of the screen
    localparam coord_x_t LANE_COLUMN [0:MAX_CARS-1] = '{
        8'd12, 8'd24, 8'd36, 8'd48, 8'd60,
        8'd72, 8'd84, 8'd96, 8'd108
    };

    // Colour generator seeds, all nonzero so no LFSR locks up
    localparam lfsr_t LANE_SEED [0:MAX_CARS-1] = '{
        8'h06, 8'h75, 8'h46, 8'h0F, 8'h91,
        8'hFE, 8'h49, 8'hDD, 8'h36
    };

    // Galois feedback mask, maximal length for 8 bits
    localparam lfsr_t LFSR_TAPS = 8'hB8;

    localparam colour_t BLACK = '0;  // Erase colour

endpackage

`default_nettype wire

//--- verilog/car_traffic_top.sv
// Top level of the lane animator; connects the step timer, one lane per car and the pixel merge
`timescale 1ns/1ps
`default_nettype none

module car_traffic_top
    import car_pkg::*;
#(
    parameter int NUM_CARS    = 9,        // No more than MAX_CARS
    parameter int STEP_PERIOD = 1_000_000 // At least 4 * NUM_CARS
)
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     run,
    output logic     plot,
    output coord_x_t plot_x,
    output coord_y_t plot_y,
    output colour_t  plot_colour
);

    logic     [NUM_CARS-1:0] step;
    logic     [NUM_CARS-1:0] pixel_valid;
    logic     [NUM_CARS-1:0] pixel_grant;
    coord_x_t [NUM_CARS-1:0] pixel_x;
    coord_y_t [NUM_CARS-1:0] pixel_y;
    colour_t  [NUM_CARS-1:0] pixel_colour;

    step_timer #(
        .NUM_CARS    (NUM_CARS),
        .STEP_PERIOD (STEP_PERIOD)
    ) u_step_timer (
        .clk     (clk),
        .reset_n (reset_n),
        .run     (run),
        .step    (step)
    );

    // Column and seed of each car come from the lane tables
    for (genvar i = 0; i < NUM_CARS; i++)
    begin : g_lane
        car_lane #(
            .LANE_X (LANE_COLUMN[i]),
            .SEED   (LANE_SEED[i])
        ) u_car_lane (
            .clk          (clk),
            .reset_n      (reset_n),
            .step         (step[i]),
            .pixel_grant  (pixel_grant[i]),
            .pixel_valid  (pixel_valid[i]),
            .pixel_x      (pixel_x[i]),
            .pixel_y      (pixel_y[i]),
            .pixel_colour (pixel_colour[i])
        );
    end

    pixel_arbiter #(
        .NUM_CARS (NUM_CARS)
    ) u_pixel_arbiter (
        .clk          (clk),
        .reset_n      (reset_n),
        .pixel_valid  (pixel_valid),
        .pixel_x      (pixel_x),
        .pixel_y      (pixel_y),
        .pixel_colour (pixel_colour),
        .pixel_grant  (pixel_grant),
        .plot         (plot),
        .plot_x       (plot_x),
        .plot_y       (plot_y),
        .plot_colour  (plot_colour)
    );

endmodule

`default_nettype wire

//--- verilog/colour_lfsr.sv
// Per-car 8-bit Galois shift register; steps on each advance pulse and gives the car colour
`timescale 1ns/1ps
`default_nettype none

module colour_lfsr
    import car_pkg::*;
#(
    parameter lfsr_t SEED = 8'h01
)
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    advance,
    output colour_t colour
);

    lfsr_t state;
    lfsr_t feedback;

    // Taps are folded in only when a one falls off the bottom
    assign feedback = state[0] ? LFSR_TAPS : lfsr_t'(0);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= SEED;
        end
        else if (advance)
        begin
            state <= (state >> 1) ^ feedback;  // Right shift, Galois form
        end
    end

    assign colour = state[COLOUR_WIDTH-1:0];  // Low bits are R, G, B

endmodule

`default_nettype wire

//--- verilog/pixel_arbiter.sv
// Fixed-priority merge of all car pixel requests into one registered plot stream
`timescale 1ns/1ps
`default_nettype none

module pixel_arbiter
    import car_pkg::*;
#(
    parameter int NUM_CARS = 9
)
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic     [NUM_CARS-1:0]       pixel_valid,
    input  coord_x_t [NUM_CARS-1:0]       pixel_x,
    input  coord_y_t [NUM_CARS-1:0]       pixel_y,
    input  colour_t  [NUM_CARS-1:0]       pixel_colour,
    output logic     [NUM_CARS-1:0]       pixel_grant,
    output logic                          plot,
    output coord_x_t                      plot_x,
    output coord_y_t                      plot_y,
    output colour_t                       plot_colour
);

    coord_x_t sel_x;
    coord_y_t sel_y;
    colour_t  sel_colour;

    // Lowest set bit wins, car 0 has top priority
    assign pixel_grant = pixel_valid & (~pixel_valid + NUM_CARS'(1));

    // One-hot OR mux over the granted car
    always_comb
    begin
        sel_x      = '0;
        sel_y      = '0;
        sel_colour = '0;
        for (int i = 0; i < NUM_CARS; i++)
        begin
            if (pixel_grant[i])
            begin
                sel_x      = sel_x | pixel_x[i];
                sel_y      = sel_y | pixel_y[i];
                sel_colour = sel_colour | pixel_colour[i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            plot <= 1'b0;
        else
            plot <= |pixel_valid;  // A valid always means one grant this cycle
    end

    always_ff @(posedge clk)
    begin
        plot_x      <= sel_x;
        plot_y      <= sel_y;
        plot_colour <= sel_colour;
    end

endmodule

`default_nettype wire

//--- verilog/step_timer.sv
// Modulo step counter that issues one staggered step pulse per car while run is high
`timescale 1ns/1ps
`default_nettype none

module step_timer
    import car_pkg::*;
#(
    parameter int NUM_CARS    = 9,
    parameter int STEP_PERIOD = 36
)
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                run,
    output logic [NUM_CARS-1:0] step
);

    localparam int CNT_WIDTH = $clog2(STEP_PERIOD);

    logic [CNT_WIDTH-1:0] count;
    logic                 count_last;

    assign count_last = (count == CNT_WIDTH'(STEP_PERIOD - 1));

    // Counter only moves while running, so a paused pulse is never skipped
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            count <= '0;
        end
        else if (run)
        begin
            if (count_last)
                count <= '0;
            else
                count <= count + CNT_WIDTH'(1);
        end
    end

    // Car i steps when the count passes i
    // One pulse per period, and no two cars start on the same clock
    for (genvar i = 0; i < NUM_CARS; i++)
    begin : g_step
        assign step[i] = run && (count == CNT_WIDTH'(i));
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+tb
verilog/car_pkg.sv
verilog/step_timer.sv
verilog/colour_lfsr.sv
verilog/car_lane.sv
verilog/pixel_arbiter.sv
verilog/car_traffic_top.sv
tb/tb_car_traffic.sv
